//--- verilog/icache_pkg.sv
// ====================
// icache shared definitions
// widths, way count and refill state encoding
// ====================
`default_nettype none

package icache_pkg;

  // fetch address and instruction width
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // associativity is fixed, one lru bit per set covers two ways
  localparam int WAYS  = 2;
  localparam int WAY_W = $clog2(WAYS);

  // address layout, low to high:
  //   [1:0] byte in word
  //   word offset in line
  //   set index
  //   tag

  // refill sequence
  typedef enum logic [1:0] {
    // waiting for a stage-1 miss
    ST_IDLE,
    // line request on the memory port
    ST_REQ,
    // collecting burst beats
    ST_FILL,
    // one-cycle line install
    ST_WRITE
  } refill_state_e;

endpackage

`default_nettype wire

//--- verilog/icache_refill_if.sv
// ====================
// icache refill write path
// ====================
`default_nettype none
`timescale 1ns/1ps

interface icache_refill_if import icache_pkg::*; #(
  parameter int SETS       = 8,
  parameter int LINE_WORDS = 4
) ();

  localparam int OFS_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W - 2;

  // line install
  logic             wr_en;
  logic [WAY_W-1:0] wr_way;
  logic [IDX_W-1:0] wr_index;
  logic [TAG_W-1:0] wr_tag;
  // burst beat capture
  logic             beat_en;
  logic [OFS_W-1:0] beat_idx;

  modport fsm  (output wr_en, wr_way, wr_index, wr_tag, beat_en, beat_idx);
  modport tags (input wr_en, wr_way, wr_index, wr_tag);
  modport data (input wr_en, wr_way, wr_index, beat_en, beat_idx);

endinterface

`default_nettype wire

//--- verilog/icache_beat_counter.sv
// ====================
// icache burst beat counter
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_beat_counter #(
  parameter int LINE_WORDS = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear_i,
  input  logic                          step_i,
  output logic [$clog2(LINE_WORDS)-1:0] beat_idx_o,
  output logic                          last_beat_o
);

  localparam int OFS_W = $clog2(LINE_WORDS);

  logic [OFS_W-1:0] cnt_q;

  // wraps on its own since LINE_WORDS is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (step_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign beat_idx_o  = cnt_q;
  // final word of the line, no rlast needed from memory
  assign last_beat_o = (cnt_q == OFS_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- verilog/icache_refill_fsm.sv
// ====================
// icache refill fsm
// requests the missed line, collects the burst, installs it
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_refill_fsm import icache_pkg::*; #(
  parameter int SETS       = 8,
  parameter int LINE_WORDS = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          miss_i,
  input  logic [ADDR_W-1:0]             miss_addr_i,
  input  logic [WAY_W-1:0]              victim_way_i,
  output logic                          mem_req_o,
  output logic [ADDR_W-1:0]             mem_addr_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic                          last_beat_i,
  input  logic [$clog2(LINE_WORDS)-1:0] beat_idx_i,
  output logic                          cnt_clear_o,
  output logic                          busy_o,
  icache_refill_if.fsm                  refill_o
);

  localparam int OFS_W   = $clog2(LINE_WORDS);
  localparam int IDX_W   = $clog2(SETS);
  localparam int IDX_LSB = OFS_W + 2;
  localparam int TAG_LSB = IDX_LSB + IDX_W;

  refill_state_e state_q;
  refill_state_e state_d;

  // line address and victim, frozen for the whole refill
  logic [ADDR_W-1:IDX_LSB] line_q;
  logic [WAY_W-1:0]        way_q;

  // ====================
  // next state
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (miss_i) state_d = ST_REQ;
      ST_REQ:   if (mem_gnt_i) state_d = ST_FILL;
      ST_FILL:  if (mem_rvalid_i && last_beat_i) state_d = ST_WRITE;
      ST_WRITE: state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture on the miss so that lru updates later on cannot move the victim
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && miss_i) begin
      line_q <= miss_addr_i[ADDR_W-1:IDX_LSB];
      way_q  <= victim_way_i;
    end
  end

  // ====================
  // outputs
  // ====================
  assign busy_o      = (state_q != ST_IDLE);
  assign mem_req_o   = (state_q == ST_REQ);
  assign mem_addr_o  = {line_q, {IDX_LSB{1'b0}}};
  // counter restarts while the request is pending
  assign cnt_clear_o = (state_q == ST_REQ);

  assign refill_o.beat_en  = (state_q == ST_FILL) && mem_rvalid_i;
  assign refill_o.beat_idx = beat_idx_i;
  assign refill_o.wr_en    = (state_q == ST_WRITE);
  assign refill_o.wr_way   = way_q;
  assign refill_o.wr_index = line_q[TAG_LSB-1:IDX_LSB];
  assign refill_o.wr_tag   = line_q[ADDR_W-1:TAG_LSB];

endmodule

`default_nettype wire

//--- verilog/icache_tag_array.sv
// ====================
// icache tag array
// tags, valid and lru per set, hit detect and victim choice
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_tag_array import icache_pkg::*; #(
  parameter int SETS       = 8,
  parameter int LINE_WORDS = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          flush_i,
  input  logic                                          rd_en_i,
  input  logic [$clog2(SETS)-1:0]                       rd_index_i,
  input  logic [ADDR_W-$clog2(SETS)-$clog2(LINE_WORDS)-3:0] cmp_tag_i,
  output logic                                          hit_o,
  output logic [WAY_W-1:0]                              hit_way_o,
  output logic [WAY_W-1:0]                              victim_way_o,
  icache_refill_if.tags                                 refill_i
);

  localparam int OFS_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFS_W - 2;

  logic [WAYS-1:0][SETS-1:0] valid_q;
  // set means way 1 is next to go
  logic [SETS-1:0]           lru_q;
  logic [IDX_W-1:0]          idx_q;
  // outputs below belong to a lookup read on the previous edge
  logic                      fresh_q;
  logic [WAYS-1:0]           match;

  // ====================
  // per-way storage
  // ====================
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_W-1:0] tag_mem [SETS];
    logic [TAG_W-1:0] rd_tag_q;
    logic             rd_vld_q;
    logic             way_we;
    logic             way_fwd;

    assign way_we  = refill_i.wr_en && (refill_i.wr_way == WAY_W'(w));
    assign way_fwd = way_we && (refill_i.wr_index == rd_index_i);

    always_ff @(posedge clk) begin
      if (way_we) begin
        tag_mem[refill_i.wr_index] <= refill_i.wr_tag;
      end
      if (rd_en_i) begin
        rd_tag_q <= way_fwd ? refill_i.wr_tag : tag_mem[rd_index_i];
      end
    end

    // a read on the flush edge already sees the line as gone
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_vld_q <= 1'b0;
      end else if (rd_en_i) begin
        rd_vld_q <= way_fwd || (valid_q[w][rd_index_i] && !flush_i);
      end
    end

    assign match[w] = rd_vld_q && (rd_tag_q == cmp_tag_i);
  end

  // a line install wins over a flush on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end
      if (refill_i.wr_en) begin
        valid_q[refill_i.wr_way][refill_i.wr_index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q   <= '0;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= rd_en_i;
      if (rd_en_i) begin
        idx_q <= rd_index_i;
      end
    end
  end

  // ====================
  // hit, lru and victim
  // ====================
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (match[w]) hit_way_o = WAY_W'(w);
    end
  end

  assign hit_o = |match;

  // point away from the way just used, once per lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lru_q <= '0;
    end else if (refill_i.wr_en) begin
      lru_q[refill_i.wr_index] <= ~refill_i.wr_way;
    end else if (fresh_q && hit_o) begin
      lru_q[idx_q] <= ~hit_way_o;
    end
  end

  // empty way first, lowest way wins
  always_comb begin
    victim_way_o = lru_q[idx_q];
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][idx_q]) victim_way_o = WAY_W'(w);
    end
  end

endmodule

`default_nettype wire

//--- verilog/icache_data_array.sv
// ====================
// icache data array
// line storage, refill buffer and word select
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_data_array import icache_pkg::*; #(
  parameter int SETS       = 8,
  parameter int LINE_WORDS = 4
) (
  input  logic                          clk,
  input  logic                          rd_en_i,
  input  logic [$clog2(SETS)-1:0]       rd_index_i,
  input  logic [$clog2(LINE_WORDS)-1:0] word_sel_i,
  input  logic [WAY_W-1:0]              hit_way_i,
  input  logic [WORD_W-1:0]             mem_rdata_i,
  output logic [WORD_W-1:0]             rdata_o,
  icache_refill_if.data                 refill_i
);

  // burst words gathered here until the install cycle
  logic [LINE_WORDS-1:0][WORD_W-1:0] fill_buf;
  logic [LINE_WORDS-1:0][WORD_W-1:0] rd_line [WAYS];

  always_ff @(posedge clk) begin
    if (refill_i.beat_en) begin
      fill_buf[refill_i.beat_idx] <= mem_rdata_i;
    end
  end

  // ====================
  // per-way lines
  // ====================
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [LINE_WORDS-1:0][WORD_W-1:0] line_mem [SETS];
    logic [LINE_WORDS-1:0][WORD_W-1:0] rd_line_q;
    logic                              way_we;
    logic                              way_fwd;

    assign way_we  = refill_i.wr_en && (refill_i.wr_way == WAY_W'(w));
    assign way_fwd = way_we && (refill_i.wr_index == rd_index_i);

    // write-first so the replay sees the line it just installed
    always_ff @(posedge clk) begin
      if (way_we) begin
        line_mem[refill_i.wr_index] <= fill_buf;
      end
      if (rd_en_i) begin
        rd_line_q <= way_fwd ? fill_buf : line_mem[rd_index_i];
      end
    end

    assign rd_line[w] = rd_line_q;
  end

  assign rdata_o = rd_line[hit_way_i][word_sel_i];

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
// ====================
// icache top
// two-way instruction cache with a two-stage lookup
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
  parameter int SETS       = 8,
  parameter int LINE_WORDS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // fetch request
  input  logic              req_valid_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  output logic              req_ready_o,
  // fetch response
  output logic              rsp_valid_o,
  output logic [WORD_W-1:0] rsp_instr_o,
  output logic [ADDR_W-1:0] rsp_addr_o,
  input  logic              rsp_ready_i,
  input  logic              flush_i,
  // memory port
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic [WORD_W-1:0] mem_rdata_i
);

  localparam int OFS_W   = $clog2(LINE_WORDS);
  localparam int IDX_W   = $clog2(SETS);
  localparam int IDX_LSB = OFS_W + 2;
  localparam int TAG_LSB = IDX_LSB + IDX_W;

  logic              s1_valid_q;
  logic [ADDR_W-1:0] s1_addr_q;
  logic              s0_ready;
  logic              hit;
  logic              miss;
  logic              fsm_busy;
  logic              rd_en;
  logic [IDX_W-1:0]  rd_index;
  logic [WAY_W-1:0]  hit_way;
  logic [WAY_W-1:0]  victim_way;
  logic              cnt_clear;
  logic              last_beat;
  logic [OFS_W-1:0]  beat_idx;

  icache_refill_if #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) refill_if ();

  // ====================
  // stage 0
  // ====================
  // stalls on a miss, a refill, or a response not yet taken
  assign s0_ready    = !fsm_busy && (!s1_valid_q || (hit && rsp_ready_i));
  assign req_ready_o = s0_ready;

  // new lookup, or the held address re-read while refilling
  assign rd_en    = (s0_ready && req_valid_i) || fsm_busy;
  assign rd_index = s0_ready ? req_addr_i[TAG_LSB-1:IDX_LSB]
                             : s1_addr_q[TAG_LSB-1:IDX_LSB];

  // ====================
  // stage 1
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (s0_ready) begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s0_ready && req_valid_i) begin
      s1_addr_q <= req_addr_i;
    end
  end

  assign miss        = s1_valid_q && !hit;
  assign rsp_valid_o = s1_valid_q && hit;
  assign rsp_addr_o  = s1_addr_q;

  icache_tag_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_tags (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .rd_en_i      (rd_en),
    .rd_index_i   (rd_index),
    .cmp_tag_i    (s1_addr_q[ADDR_W-1:TAG_LSB]),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .refill_i     (refill_if.tags)
  );

  icache_data_array #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_data (
    .clk         (clk),
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .word_sel_i  (s1_addr_q[IDX_LSB-1:2]),
    .hit_way_i   (hit_way),
    .mem_rdata_i (mem_rdata_i),
    .rdata_o     (rsp_instr_o),
    .refill_i    (refill_if.data)
  );

  // ====================
  // refill
  // ====================
  icache_refill_fsm #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .miss_i       (miss),
    .miss_addr_i  (s1_addr_q),
    .victim_way_i (victim_way),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .last_beat_i  (last_beat),
    .beat_idx_i   (beat_idx),
    .cnt_clear_o  (cnt_clear),
    .busy_o       (fsm_busy),
    .refill_o     (refill_if.fsm)
  );

  icache_beat_counter #(.LINE_WORDS(LINE_WORDS)) u_beats (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (cnt_clear),
    .step_i      (refill_if.beat_en),
    .beat_idx_o  (beat_idx),
    .last_beat_o (last_beat)
  );

endmodule

`default_nettype wire

//--- testbench/icache_properties.sv
// ====================
// icache properties
// handshake and refill rules, bound to icache_top
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_properties import icache_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic              mem_req_i,
  input logic              mem_gnt_i,
  input logic              rsp_valid_i,
  input logic [WORD_W-1:0] rsp_instr_i,
  input logic [ADDR_W-1:0] rsp_addr_i,
  input logic              rsp_ready_i,
  input logic              busy_i,
  input logic              wr_en_i
);

  // failure count, read by the testbench at the end of the run
  int unsigned fails = 0;

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i && !mem_gnt_i |=> mem_req_i)
    else begin
      $error("memory request dropped before it was granted");
      fails++;
    end

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i && !rsp_ready_i |=>
      rsp_valid_i && $stable(rsp_instr_i) && $stable(rsp_addr_i))
    else begin
      $error("response changed while it was held back");
      fails++;
    end

  a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en_i |=> !wr_en_i)
    else begin
      $error("line write strobe lasted more than one cycle");
      fails++;
    end

  // the replay hit only shows once the refill has gone idle
  a_busy_no_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    busy_i |-> !rsp_valid_i)
    else begin
      $error("response raised while a refill was busy");
      fails++;
    end

endmodule

bind icache_top icache_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .mem_req_i   (mem_req_o),
  .mem_gnt_i   (mem_gnt_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_instr_i (rsp_instr_o),
  .rsp_addr_i  (rsp_addr_o),
  .rsp_ready_i (rsp_ready_i),
  .busy_i      (fsm_busy),
  .wr_en_i     (refill_if.wr_en)
);

`default_nettype wire

//--- testbench/icache_checker.sv
// ====================
// icache checker
// tag, valid and lru model, response and memory request comparison
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; #(
  parameter int          SETS       = 8,
  parameter int          LINE_WORDS = 4,
  parameter logic [31:0] MEM_KEY    = 32'h0
) (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid_i,
  input logic [ADDR_W-1:0] req_addr_i,
  input logic              req_ready_i,
  input logic              rsp_valid_i,
  input logic [WORD_W-1:0] rsp_instr_i,
  input logic [ADDR_W-1:0] rsp_addr_i,
  input logic              rsp_ready_i,
  input logic              flush_i,
  input logic              mem_req_i,
  input logic [ADDR_W-1:0] mem_addr_i,
  input logic              mem_gnt_i
);

  localparam int IDX_LSB = $clog2(LINE_WORDS) + 2;
  localparam int TAG_LSB = IDX_LSB + $clog2(SETS);

  bit [ADDR_W-1:0]   m_tag [WAYS][SETS];
  bit                m_vld [WAYS][SETS];
  // way that goes next in each set
  bit                m_lru [SETS];
  logic [ADDR_W-1:0] rsp_q [$];
  logic [ADDR_W-1:0] mem_q [$];
  bit                pend_q;
  bit                pend_hit_q;
  logic [ADDR_W-1:0] pend_addr_q;
  string             test_name = "none";
  int                checks = 0;
  int                errors = 0;
  int                tests = 0;
  int                failed_tests = 0;
  int                err_base = 0;
  int                chk_base = 0;

  function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:2], 2'b00} ^ MEM_KEY;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // ====================
  // cache model
  // ====================
  task automatic predict(input logic [ADDR_W-1:0] addr, output bit hit);
    int              idx;
    int              way;
    bit [ADDR_W-1:0] tag;
    idx = int'(addr[TAG_LSB-1:IDX_LSB]);
    tag = addr >> TAG_LSB;
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_vld[w][idx] && m_tag[w][idx] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // empty way first, way 0 before way 1, then the lru way
      if (!m_vld[0][idx])
        way = 0;
      else if (!m_vld[1][idx])
        way = 1;
      else
        way = m_lru[idx];
      m_vld[way][idx] = 1'b1;
      m_tag[way][idx] = tag;
      mem_q.push_back((addr >> IDX_LSB) << IDX_LSB);
    end
    m_lru[idx] = (way == 0);
  endtask

  always @(posedge clk) begin : watch
    logic [ADDR_W-1:0] exp_addr;
    bit                hit;
    if (!rst_n) begin
      foreach (m_vld[w, s]) m_vld[w][s] = 1'b0;
      foreach (m_lru[s]) m_lru[s] = 1'b0;
      pend_q = 1'b0;
    end else begin
      // a hit answers exactly one cycle after acceptance, a miss never does
      if (pend_q) begin
        checks++;
        if (pend_hit_q && !rsp_valid_i)
          report_problem($sformatf("hit on %h gave no response one cycle later", pend_addr_q));
        else if (!pend_hit_q && rsp_valid_i)
          report_problem($sformatf("miss on %h was answered without a refill", pend_addr_q));
        pend_q = 1'b0;
      end
      if (rsp_valid_i && rsp_ready_i) begin
        if (rsp_q.size() == 0) begin
          report_problem("response arrived with no request outstanding");
        end else begin
          exp_addr = rsp_q.pop_front();
          check_value("rsp_addr", exp_addr, rsp_addr_i);
          check_value("rsp_instr", word_at(exp_addr), rsp_instr_i);
        end
      end
      if (mem_req_i && mem_gnt_i) begin
        if (mem_q.size() == 0)
          report_problem($sformatf("memory request for %h was not expected", mem_addr_i));
        else
          check_value("mem_addr", mem_q.pop_front(), mem_addr_i);
      end
      if (flush_i) begin
        foreach (m_vld[w, s]) m_vld[w][s] = 1'b0;
      end
      if (req_valid_i && req_ready_i) begin
        predict(req_addr_i, hit);
        rsp_q.push_back(req_addr_i);
        pend_q      = 1'b1;
        pend_hit_q  = hit;
        pend_addr_q = req_addr_i;
      end
    end
  end

  // ====================
  // test reporting
  // ====================
  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic end_test();
    if (rsp_q.size() != 0 || mem_q.size() != 0) begin
      report_problem("requests still outstanding at the end of the test");
    end
    tests++;
    if (errors != err_base) failed_tests++;
    $display("test %s: %0d checks, %0d errors", test_name, checks - chk_base, errors - err_base);
    err_base = errors;
    chk_base = checks;
  endtask

  task automatic summary(input int assert_fails);
    $display("tests %0d, failing tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, failed_tests, checks, errors, assert_fails);
  endtask

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
// ====================
// icache testbench
// directed and random fetches against a random-latency memory
// ====================
`default_nettype none
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

  localparam int          SETS        = 8;
  localparam int          LINE_WORDS  = 4;
  localparam logic [31:0] MEM_KEY     = 32'hA5C3_1E69;
  localparam int          N_BP        = 40;
  localparam int          N_MIX       = 300;
  localparam int          N_REQ       = 1 + 4 + 6 + 3 + N_BP + N_MIX;
  localparam int          GNT_MAX     = 3;
  localparam int          GAP_MAX     = 2;
  localparam int          REFILL_MAX  = GNT_MAX + 1 + LINE_WORDS * (GAP_MAX + 1) + 4;
  localparam int          CYCLE_LIMIT = N_REQ * REFILL_MAX + 500;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req_valid_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic              req_ready_o;
  logic              rsp_valid_o;
  logic [WORD_W-1:0] rsp_instr_o;
  logic [ADDR_W-1:0] rsp_addr_o;
  logic              rsp_ready_i;
  logic              flush_i;
  logic              mem_req_o;
  logic [ADDR_W-1:0] mem_addr_o;
  logic              mem_gnt_i;
  logic              mem_rvalid_i;
  logic [WORD_W-1:0] mem_rdata_i;
  integer            seed = 14;
  bit                bp_on = 1'b0;
  int                cycles;

  always #5 clk = ~clk;

  icache_top #(.SETS(SETS), .LINE_WORDS(LINE_WORDS)) uut (.*);

  icache_checker #(.SETS(SETS), .LINE_WORDS(LINE_WORDS), .MEM_KEY(MEM_KEY)) chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_instr_i (rsp_instr_o),
    .rsp_addr_i  (rsp_addr_o),
    .rsp_ready_i (rsp_ready_i),
    .flush_i     (flush_i),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .mem_gnt_i   (mem_gnt_i)
  );

  // ====================
  // memory and response side
  // ====================
  // grant after 0 to 3 cycles, beats with 0 to 2 idle cycles between them
  always begin : mem_responder
    logic [ADDR_W-1:0] line;
    @(negedge clk);
    if (mem_req_o) begin
      line = mem_addr_o;
      repeat ($unsigned($random(seed)) % (GNT_MAX + 1)) @(negedge clk);
      mem_gnt_i = 1'b1;
      @(negedge clk);
      mem_gnt_i = 1'b0;
      for (int b = 0; b < LINE_WORDS; b++) begin
        repeat ($unsigned($random(seed)) % (GAP_MAX + 1)) @(negedge clk);
        mem_rvalid_i = 1'b1;
        mem_rdata_i  = (line + ADDR_W'(4 * b)) ^ MEM_KEY;
        @(negedge clk);
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
      end
    end
  end

  always @(negedge clk) begin
    if (bp_on)
      rsp_ready_i = ($random(seed) & 1) != 0;
    else
      rsp_ready_i = 1'b1;
  end

  // ====================
  // stimulus
  // ====================
  task automatic fetch(input logic [ADDR_W-1:0] addr);
    logic taken;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    taken       = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = req_ready_o;
      @(negedge clk);
    end
    req_valid_i = 1'b0;
  endtask

  // idle once stage 1 is empty and no refill runs
  task automatic drain();
    do @(negedge clk); while (!(req_ready_o && !rsp_valid_o));
  endtask

  task automatic random_fetches(input int count);
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < count; i++) begin
      // four tags per set over this range
      addr = $unsigned($random(seed)) & 32'h0000_01FC;
      if (($random(seed) & 3) == 0) @(negedge clk);
      fetch(addr);
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int total;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    rsp_ready_i  = 1'b1;
    flush_i      = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    chk.start_test("cold_miss");
    fetch(32'h0000_1008);
    drain();
    chk.end_test();

    chk.start_test("line_hits");
    for (int i = 0; i < 4; i++) fetch(32'h0000_1000 + 4 * i);
    drain();
    chk.end_test();

    // three tags in set 2, then the evicted one again
    chk.start_test("lru_evict");
    fetch(32'h0000_2020);
    fetch(32'h0000_4024);
    fetch(32'h0000_2028);
    fetch(32'h0000_6020);
    fetch(32'h0000_202C);
    fetch(32'h0000_4020);
    drain();
    chk.end_test();

    chk.start_test("flush_all");
    fetch(32'h0000_1000);
    drain();
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    fetch(32'h0000_1004);
    fetch(32'h0000_202C);
    drain();
    chk.end_test();

    chk.start_test("backpressure");
    bp_on = 1'b1;
    random_fetches(N_BP);
    drain();
    bp_on = 1'b0;
    chk.end_test();

    chk.start_test("random_mix");
    random_fetches(N_MIX);
    drain();
    chk.end_test();

    total = chk.errors + uut.u_props.fails;
    chk.summary(uut.u_props.fails);
    if (total == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/icache_pkg.sv
verilog/icache_refill_if.sv
verilog/icache_beat_counter.sv
verilog/icache_refill_fsm.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_top.sv
testbench/icache_properties.sv
testbench/icache_checker.sv
testbench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_refill_if.sv
      - verilog/icache_beat_counter.sv
      - verilog/icache_refill_fsm.sv
      - verilog/icache_tag_array.sv
      - verilog/icache_data_array.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - testbench/icache_properties.sv
      - testbench/icache_checker.sv
      - testbench/icache_tb.sv
